// File: source/agu_params.svh
`ifndef AGU_PARAMS_SVH
`define AGU_PARAMS_SVH

// address widths
`define AGU_VADDR_W 44
`define AGU_PADDR_W 44

// 8 KB pages, 128 byte lines
`define AGU_PAGE_SHIFT 13
`define AGU_LINE_SHIFT 7

`define AGU_BANKS 32

// context tag width, csr_data bits 63:43
`define AGU_CTX_W 21

`define AGU_TLB_ENTRIES 8
`define AGU_REGNO_W 9

// csr numbers
`define AGU_CSR_PAGE 16'h0010
`define AGU_CSR_MFLAGS 16'h0011

`endif

// File: source/agu_pkg.sv
`include "agu_params.svh"

package agu_pkg;

  typedef logic [`AGU_VADDR_W-`AGU_PAGE_SHIFT-1:0] vpage_t;
  typedef logic [`AGU_PADDR_W-`AGU_PAGE_SHIFT-1:0] ppage_t;

  // one translation, 33 bits
  typedef struct packed {
    ppage_t ppage;
    logic   sys;
    logic   present;
  } tlb_entry_t;

  typedef struct packed {
    logic priv;
    logic absent;
  } fault_t;

  // memory operation as it enters the stage
  typedef struct packed {
    logic [`AGU_VADDR_W-1:0] vaddr;
    logic [4:0]              size;
    logic [4:0]              bank0;
    logic                    split;
    logic                    st;
    logic [`AGU_REGNO_W-1:0] regno;
  } mop_t;

  // system pages are off limits at user level (cpl 3)
  function automatic fault_t entry_fault(tlb_entry_t e, logic [1:0] cpl);
    fault_t f;
    f.priv   = e.sys && (cpl == 2'd3);
    f.absent = !e.present;
    return f;
  endfunction

endpackage

// File: source/tlb_lookup_if.sv
`include "agu_params.svh"

interface tlb_lookup_if;
  // lookup, answered in the same cycle
  logic                   lookup_en;
  agu_pkg::vpage_t        vpage;
  agu_pkg::vpage_t        vpage_next;
  logic [`AGU_CTX_W-1:0]  ctx;
  logic                   hit;
  logic                   hit_next;
  agu_pkg::tlb_entry_t    entry;
  agu_pkg::tlb_entry_t    entry_next;

  // fill strobe, written at the next edge
  logic                   fill_en;
  logic [`AGU_CTX_W-1:0]  fill_ctx;
  agu_pkg::vpage_t        fill_vpage;
  agu_pkg::tlb_entry_t    fill_entry;

  modport stage (output lookup_en, vpage, vpage_next, ctx,
                 input hit, hit_next, entry, entry_next);

  modport tlb (input lookup_en, vpage, vpage_next, ctx,
               input fill_en, fill_ctx, fill_vpage, fill_entry,
               output hit, hit_next, entry, entry_next);

  modport filler (output fill_en, fill_ctx, fill_vpage, fill_entry);
endinterface

// File: source/bank_mask.sv
`include "agu_params.svh"

module bank_mask (
  input  logic [4:0]            size,
  input  logic [4:0]            bank0,
  input  logic [1:0]            addr_low,
  output logic [`AGU_BANKS-1:0] banks
);

  logic [2:0] size_class;
  logic [2:0] extra;
  logic       any_low;
  logic       both_low;

  assign any_low  = |addr_low;
  assign both_low = &addr_low;

  // size code to span class
  always_comb begin
    case (size)
      5'd16: size_class = 3'd0;
      5'd17: size_class = 3'd1;
      5'd18: size_class = 3'd2;
      5'd19: size_class = 3'd3;
      5'd3: size_class = 3'd4;
      5'd0, 5'd1, 5'd2, 5'd12, 5'd13, 5'd14: size_class = 3'd5;
      5'd4, 5'd5, 5'd6: size_class = 3'd2;
      5'd8, 5'd9, 5'd10: size_class = 3'd3;
      5'd15: size_class = 3'd6;
      default: size_class = 3'd3;
    endcase
  end

  // banks beyond bank0, a misaligned start adds one
  always_comb begin
    case (size_class)
      3'd0: extra = 3'd0;
      3'd1: extra = both_low ? 3'd1 : 3'd0;
      3'd2: extra = any_low ? 3'd1 : 3'd0;
      3'd3: extra = any_low ? 3'd2 : 3'd1;
      3'd4: extra = both_low ? 3'd3 : 3'd2;
      3'd5: extra = any_low ? 3'd4 : 3'd3;
      default: extra = 3'd4;
    endcase
  end

  always_comb begin
    banks = '0;
    for (int k = 0; k <= 4; k++) begin
      // bank index wraps at 32
      if (k <= int'(extra)) banks[5'(bank0 + 5'(k))] = 1'b1;
    end
  end

endmodule

// File: source/agu_ctx.sv
`include "agu_params.svh"

module agu_ctx (
  input  logic                  clk,
  input  logic                  rst,
  input  logic                  csr_en,
  input  logic [15:0]           csr_no,
  input  logic [63:0]           csr_data,
  input  logic                  except,
  input  logic                  except_gate,
  input  logic                  except_in_km,
  output logic [`AGU_CTX_W-1:0] ctx,
  output logic [1:0]            cpl
);

  // context to return to on an exception
  logic [`AGU_CTX_W-1:0] saved_ctx;

  always_ff @(posedge clk) begin
    if (rst) begin
      ctx       <= '0;
      saved_ctx <= '0;
      cpl       <= 2'd0;
    end else if (except && except_gate) begin
      // exception wins over a csr write
      ctx <= saved_ctx;
      cpl <= except_in_km ? 2'd0 : 2'd3;
    end else if (csr_en) begin
      if (csr_no == `AGU_CSR_PAGE) begin
        ctx       <= csr_data[63:64-`AGU_CTX_W];
        saved_ctx <= csr_data[63:64-`AGU_CTX_W];
      end
      if (csr_no == `AGU_CSR_MFLAGS) begin
        cpl <= csr_data[1:0];
      end
    end
  end

endmodule

// File: source/dtlb_small.sv
`include "agu_params.svh"

module dtlb_small (
  input logic       clk,
  input logic       rst,
  tlb_lookup_if.tlb lk
);

  localparam int N     = `AGU_TLB_ENTRIES;
  localparam int IDX_W = $clog2(`AGU_TLB_ENTRIES);

  logic [N-1:0]          valid;
  logic [`AGU_CTX_W-1:0] tag_ctx [N];
  agu_pkg::vpage_t       tag_vp  [N];
  agu_pkg::tlb_entry_t   data    [N];

  logic [IDX_W-1:0] rr_ptr;
  logic [IDX_W-1:0] fill_idx;
  logic             fill_hit;
  logic [N-1:0]     match;
  logic [N-1:0]     match_next;

  // both pages compared against every entry in parallel
  always_comb begin
    lk.entry      = '0;
    lk.entry_next = '0;
    for (int i = 0; i < N; i++) begin
      match[i]      = valid[i] && tag_ctx[i] == lk.ctx && tag_vp[i] == lk.vpage;
      match_next[i] = valid[i] && tag_ctx[i] == lk.ctx && tag_vp[i] == lk.vpage_next;
      if (match[i]) lk.entry = data[i];
      if (match_next[i]) lk.entry_next = data[i];
    end
  end

  assign lk.hit      = lk.lookup_en && |match;
  assign lk.hit_next = lk.lookup_en && |match_next;

  // reuse an entry with the same tag, else take the round-robin slot
  always_comb begin
    fill_hit = 1'b0;
    fill_idx = rr_ptr;
    for (int i = 0; i < N; i++) begin
      if (valid[i] && tag_ctx[i] == lk.fill_ctx && tag_vp[i] == lk.fill_vpage) begin
        fill_hit = 1'b1;
        fill_idx = IDX_W'(i);
      end
    end
  end

  always_ff @(posedge clk) begin
    if (rst) begin
      valid  <= '0;
      rr_ptr <= '0;
    end else if (lk.fill_en) begin
      valid[fill_idx] <= 1'b1;
      if (!fill_hit) rr_ptr <= rr_ptr + 1'b1;
    end
  end

  always_ff @(posedge clk) begin
    if (lk.fill_en) begin
      tag_ctx[fill_idx] <= lk.fill_ctx;
      tag_vp[fill_idx]  <= lk.fill_vpage;
      data[fill_idx]    <= lk.fill_entry;
    end
  end

endmodule

// File: source/agu_stage.sv
`include "agu_params.svh"

module agu_stage (
  input  logic                          clk,
  input  logic                          rst,
  input  logic                          op_en,
  input  agu_pkg::mop_t                 op,
  input  logic                          except,
  input  logic                          bus_hold,
  input  logic [`AGU_CTX_W-1:0]         ctx,
  input  logic [1:0]                    cpl,
  tlb_lookup_if.stage                   lk,
  output logic                          stall,
  output logic                          mop_en,
  output logic                          tlb_miss,
  output logic [`AGU_BANKS-1:0]         banks,
  output logic [`AGU_PADDR_W-1:8]       addr_even,
  output logic [`AGU_PADDR_W-1:8]       addr_odd,
  output logic                          odd,
  output logic [`AGU_REGNO_W-1:0]       regno,
  output logic                          page_fault,
  output logic [7:0]                    fault_code,
  output logic [8:0]                    fault_no
);

  localparam int LINE_W = `AGU_PAGE_SHIFT - `AGU_LINE_SHIFT;

  logic                  valid;
  agu_pkg::mop_t         op_q;
  logic [LINE_W-1:0]     line;
  logic [LINE_W-1:0]     next_line;
  logic [LINE_W-1:0]     even_line;
  logic [LINE_W-1:0]     odd_line;
  logic [LINE_W:0]       line_sum;
  logic                  crossing;
  logic                  use_next;
  logic                  hit;
  logic [`AGU_BANKS-1:0] mask;
  agu_pkg::ppage_t       even_page;
  agu_pkg::ppage_t       odd_page;
  agu_pkg::fault_t       fault_cur;
  agu_pkg::fault_t       fault_nxt;
  agu_pkg::fault_t       fault_used;
  agu_pkg::fault_t       fault_q;

  // operation register, except kills it
  always_ff @(posedge clk) begin
    if (rst) valid <= 1'b0;
    else if (except) valid <= 1'b0;
    else if (!stall) valid <= op_en;
  end

  always_ff @(posedge clk) begin
    if (!stall && !except && op_en) op_q <= op;
  end

  // line index plus one, carry out means the next page
  assign line      = op_q.vaddr[`AGU_PAGE_SHIFT-1:`AGU_LINE_SHIFT];
  assign line_sum  = {1'b0, line} + 1'b1;
  assign next_line = line_sum[LINE_W-1:0];
  assign crossing  = line_sum[LINE_W];
  assign use_next  = op_q.split && crossing;

  assign lk.lookup_en  = valid;
  assign lk.vpage      = op_q.vaddr[`AGU_VADDR_W-1:`AGU_PAGE_SHIFT];
  assign lk.vpage_next = lk.vpage + 1'b1;
  assign lk.ctx        = ctx;

  assign hit      = lk.hit && (!use_next || lk.hit_next);
  assign tlb_miss = valid && !hit;
  assign stall    = tlb_miss || bus_hold;
  assign mop_en   = valid && hit && !bus_hold;

  // odd line first: the even half sits in the following line
  assign odd       = op_q.vaddr[`AGU_LINE_SHIFT];
  assign even_line = odd ? next_line : line;
  assign odd_line  = odd ? line : next_line;

  // only an odd start can carry into the next page
  assign even_page = (odd && crossing) ? lk.entry_next.ppage : lk.entry.ppage;
  assign odd_page  = lk.entry.ppage;

  assign addr_even = {even_page, even_line[LINE_W-1:1]};
  assign addr_odd  = {odd_page, odd_line[LINE_W-1:1]};
  assign regno     = op_q.regno;

  bank_mask i_bank_mask (
    .size     (op_q.size),
    .bank0    (op_q.bank0),
    .addr_low (op_q.vaddr[1:0]),
    .banks    (mask)
  );

  assign banks = mop_en ? mask : '0;

  // faults of every page the access touches
  assign fault_cur  = agu_pkg::entry_fault(lk.entry, cpl);
  assign fault_nxt  = agu_pkg::entry_fault(lk.entry_next, cpl);
  assign fault_used = fault_cur | (use_next ? fault_nxt : 2'b00);

  always_ff @(posedge clk) begin
    if (rst) fault_q <= '0;
    else fault_q <= mop_en ? fault_used : 2'b00;
  end

  assign page_fault = (|fault_q) && !bus_hold;
  assign fault_code = {4'b0, fault_q.priv, 2'b0, fault_q.absent};
  assign fault_no   = page_fault ? 9'h59 : 9'h2;

endmodule

// File: source/agu_top.sv
`include "agu_params.svh"

module agu_top (
  input  logic                                   clk,
  input  logic                                   rst,
  input  logic                                   op_en,
  input  logic [`AGU_VADDR_W-1:0]                op_addr,
  input  logic [4:0]                             op_size,
  input  logic [4:0]                             op_bank0,
  input  logic                                   op_split,
  input  logic                                   op_st,
  input  logic [`AGU_REGNO_W-1:0]                op_regno,
  input  logic                                   except,
  input  logic                                   except_gate,
  input  logic                                   except_in_km,
  input  logic                                   bus_hold,
  input  logic                                   csr_en,
  input  logic [15:0]                            csr_no,
  input  logic [63:0]                            csr_data,
  input  logic                                   fill_en,
  input  logic [`AGU_CTX_W-1:0]                  fill_ctx,
  input  logic [`AGU_VADDR_W-`AGU_PAGE_SHIFT-1:0] fill_vpage,
  input  logic [`AGU_PADDR_W-`AGU_PAGE_SHIFT-1:0] fill_ppage,
  input  logic                                   fill_sys,
  input  logic                                   fill_present,
  output logic                                   stall,
  output logic                                   mop_en,
  output logic                                   tlb_miss,
  output logic [`AGU_BANKS-1:0]                  banks,
  output logic [`AGU_PADDR_W-1:8]                addr_even,
  output logic [`AGU_PADDR_W-1:8]                addr_odd,
  output logic                                   odd,
  output logic [`AGU_REGNO_W-1:0]                regno,
  output logic                                   page_fault,
  output logic [7:0]                             fault_code,
  output logic [8:0]                             fault_no
);

  logic [`AGU_CTX_W-1:0] ctx;
  logic [1:0]            cpl;
  agu_pkg::mop_t         op;

  tlb_lookup_if lk_if ();

  assign op = {op_addr, op_size, op_bank0, op_split, op_st, op_regno};

  // fill port from the outside agent
  assign lk_if.fill_en    = fill_en;
  assign lk_if.fill_ctx   = fill_ctx;
  assign lk_if.fill_vpage = fill_vpage;
  assign lk_if.fill_entry = {fill_ppage, fill_sys, fill_present};

  agu_ctx i_ctx (
    .clk (clk), .rst (rst), .csr_en (csr_en), .csr_no (csr_no), .csr_data (csr_data),
    .except (except), .except_gate (except_gate), .except_in_km (except_in_km),
    .ctx (ctx), .cpl (cpl)
  );

  dtlb_small i_tlb (.clk (clk), .rst (rst), .lk (lk_if.tlb));

  agu_stage i_stage (
    .clk (clk), .rst (rst), .op_en (op_en), .op (op), .except (except),
    .bus_hold (bus_hold), .ctx (ctx), .cpl (cpl), .lk (lk_if.stage),
    .stall (stall), .mop_en (mop_en), .tlb_miss (tlb_miss), .banks (banks),
    .addr_even (addr_even), .addr_odd (addr_odd), .odd (odd), .regno (regno),
    .page_fault (page_fault), .fault_code (fault_code), .fault_no (fault_no)
  );

endmodule

// File: dv/agu_asserts.sv
module agu_asserts (
  input logic clk,
  input logic rst,
  input logic mop_en,
  input logic tlb_miss,
  input logic bus_hold,
  input logic page_fault
);
  timeunit 1ns;
  timeprecision 1ns;

  a_miss_excl: assert property (@(posedge clk) disable iff (rst) !(mop_en && tlb_miss))
    else $error("mop_en and tlb_miss high in the same cycle");

  a_hold_quiet: assert property (@(posedge clk) disable iff (rst) bus_hold |-> !mop_en)
    else $error("mop_en high while bus_hold is high");

  // fault register is loaded only from a completing operation
  a_fault_after_mop: assert property (@(posedge clk) disable iff (rst) page_fault |-> $past(mop_en))
    else $error("page_fault without mop_en in the cycle before");

endmodule

bind agu_top agu_asserts i_asserts (.*);

// File: dv/agu_checker.sv
`include "agu_params.svh"

module agu_checker (
  input logic                  clk,
  input logic                  rst,
  input logic                  op_en,
  input logic [43:0]           op_addr,
  input logic [4:0]            op_size,
  input logic [4:0]            op_bank0,
  input logic                  op_split,
  input logic [8:0]            op_regno,
  input logic                  except,
  input logic                  except_gate,
  input logic                  except_in_km,
  input logic                  bus_hold,
  input logic                  csr_en,
  input logic [15:0]           csr_no,
  input logic [63:0]           csr_data,
  input logic                  fill_en,
  input logic [20:0]           fill_ctx,
  input logic [30:0]           fill_vpage,
  input logic [30:0]           fill_ppage,
  input logic                  fill_sys,
  input logic                  fill_present,
  input logic                  stall,
  input logic                  mop_en,
  input logic                  tlb_miss,
  input logic [31:0]           banks,
  input logic [43:8]           addr_even,
  input logic [43:8]           addr_odd,
  input logic                  odd,
  input logic [8:0]            regno,
  input logic                  page_fault,
  input logic [7:0]            fault_code,
  input logic [8:0]            fault_no
);
  timeunit 1ns;
  timeprecision 1ns;

  int errors = 0;

  // translation cache as the TLB should hold it
  logic        m_val [8];
  logic [20:0] m_ctx [8];
  logic [30:0] m_vp  [8];
  logic [30:0] m_pp  [8];
  logic        m_sys [8];
  logic        m_pres [8];
  int          m_rr;

  logic [20:0] ctx_m;
  logic [20:0] saved_m;
  logic [1:0]  cpl_m;
  logic        valid_m;
  logic [43:0] h_addr;
  logic [4:0]  h_size;
  logic [4:0]  h_bank0;
  logic        h_split;
  logic [8:0]  h_regno;
  logic [1:0]  fault_prev;

  logic        hit_m;
  logic        stall_m;
  logic        exp_mop;
  logic        exp_pf;
  logic [43:8] exp_even;
  logic [43:8] exp_odd;
  logic        exp_priv;
  logic        exp_absent;
  int          slot;

  // span table of the bank decoder
  function automatic logic [31:0] bank_ref(logic [4:0] size, logic [4:0] bank0, logic [1:0] low);
    int          cls;
    int          n;
    logic [31:0] m;
    logic        any;
    logic        both;
    any  = |low;
    both = &low;
    if (size >= 16 && size <= 19) cls = size - 16;
    else if (size == 3) cls = 4;
    else if (size <= 2 || (size >= 12 && size <= 14)) cls = 5;
    else if (size >= 4 && size <= 6) cls = 2;
    else if (size == 15) cls = 6;
    else cls = 3;
    case (cls)
      0: n = 0;
      1: n = both ? 1 : 0;
      2: n = any ? 1 : 0;
      3: n = any ? 2 : 1;
      4: n = both ? 3 : 2;
      5: n = any ? 4 : 3;
      default: n = 4;
    endcase
    m = '0;
    for (int k = 0; k <= n; k++) m[(bank0 + k) % 32] = 1'b1;
    return m;
  endfunction

  function automatic logic find(logic [20:0] c, logic [30:0] vp, output logic [30:0] pp,
                                output logic sys, output logic pres);
    pp   = '0;
    sys  = 1'b0;
    pres = 1'b0;
    for (int i = 0; i < 8; i++) begin
      if (m_val[i] && m_ctx[i] == c && m_vp[i] == vp) begin
        pp   = m_pp[i];
        sys  = m_sys[i];
        pres = m_pres[i];
        return 1'b1;
      end
    end
    return 1'b0;
  endfunction

  // expected translation of the held operation
  task automatic evaluate();
    logic        h0;
    logic        h1;
    logic [30:0] p0;
    logic [30:0] p1;
    logic        s0;
    logic        s1;
    logic        pr0;
    logic        pr1;
    logic [5:0]  line;
    logic [5:0]  el;
    logic [5:0]  ol;
    logic [6:0]  sum;
    logic        o;
    logic        use_nx;
    h0 = find(ctx_m, h_addr[43:13], p0, s0, pr0);
    h1 = find(ctx_m, h_addr[43:13] + 31'd1, p1, s1, pr1);
    line   = h_addr[12:7];
    sum    = {1'b0, line} + 7'd1;
    o      = h_addr[7];
    use_nx = h_split && sum[6];
    hit_m  = valid_m && h0 && (!use_nx || h1);
    el     = o ? sum[5:0] : line;
    ol     = o ? line : sum[5:0];
    exp_even   = {(o && sum[6]) ? p1 : p0, el[5:1]};
    exp_odd    = {p0, ol[5:1]};
    exp_priv   = (s0 || (use_nx && s1)) && cpl_m == 2'd3;
    exp_absent = !pr0 || (use_nx && !pr1);
  endtask

  task automatic check(string name, logic [63:0] got, logic [63:0] exp);
    if (got !== exp) begin
      errors++;
      $display("ERR %0t %s got %h expected %h", $time, name, got, exp);
    end
  endtask

  always @(posedge clk) begin
    if (rst) begin
      for (int i = 0; i < 8; i++) m_val[i] = 1'b0;
      m_rr       = 0;
      ctx_m      = '0;
      saved_m    = '0;
      cpl_m      = 2'd0;
      valid_m    = 1'b0;
      fault_prev = 2'b00;
    end else begin
      evaluate();
      stall_m = (valid_m && !hit_m) || bus_hold;
      if (except) begin
        valid_m = 1'b0;
      end else if (!stall_m) begin
        valid_m = op_en;
        if (op_en) begin
          h_addr  = op_addr;
          h_size  = op_size;
          h_bank0 = op_bank0;
          h_split = op_split;
          h_regno = op_regno;
        end
      end
      if (fill_en) begin
        slot = -1;
        for (int i = 0; i < 8; i++)
          if (m_val[i] && m_ctx[i] == fill_ctx && m_vp[i] == fill_vpage) slot = i;
        if (slot < 0) begin
          slot = m_rr;
          m_rr = (m_rr + 1) % 8;
        end
        m_val[slot]  = 1'b1;
        m_ctx[slot]  = fill_ctx;
        m_vp[slot]   = fill_vpage;
        m_pp[slot]   = fill_ppage;
        m_sys[slot]  = fill_sys;
        m_pres[slot] = fill_present;
      end
      if (except && except_gate) begin
        ctx_m = saved_m;
        cpl_m = except_in_km ? 2'd0 : 2'd3;
      end else if (csr_en) begin
        if (csr_no == `AGU_CSR_PAGE) begin
          ctx_m   = csr_data[63:43];
          saved_m = csr_data[63:43];
        end
        if (csr_no == `AGU_CSR_MFLAGS) cpl_m = csr_data[1:0];
      end
    end
  end

  // outputs are settled by the falling edge
  always @(negedge clk) begin
    if (!rst) begin
      evaluate();
      exp_mop = hit_m && !bus_hold;
      check("mop_en", 64'(mop_en), 64'(exp_mop));
      check("tlb_miss", 64'(tlb_miss), 64'(valid_m && !hit_m));
      check("stall", 64'(stall), 64'((valid_m && !hit_m) || bus_hold));
      exp_pf = (|fault_prev) && !bus_hold;
      check("page_fault", 64'(page_fault), 64'(exp_pf));
      check("fault_no", 64'(fault_no), exp_pf ? 64'h59 : 64'h2);
      if (exp_pf) check("fault_code", 64'(fault_code), 64'({fault_prev[1], 2'b0, fault_prev[0]}));
      if (exp_mop) begin
        check("banks", 64'(banks), 64'(bank_ref(h_size, h_bank0, h_addr[1:0])));
        check("addr_even", 64'(addr_even), 64'(exp_even));
        check("addr_odd", 64'(addr_odd), 64'(exp_odd));
        check("odd", 64'(odd), 64'(h_addr[7]));
        check("regno", 64'(regno), 64'(h_regno));
      end else begin
        check("banks", 64'(banks), 64'h0);
      end
      fault_prev = exp_mop ? {exp_priv, exp_absent} : 2'b00;
    end
  end

endmodule

// File: dv/agu_tb.sv
`include "agu_params.svh"

module agu_tb;
  timeunit 1ns;
  timeprecision 1ns;

  logic        clk;
  logic        rst;
  logic        op_en;
  logic [43:0] op_addr;
  logic [4:0]  op_size;
  logic [4:0]  op_bank0;
  logic        op_split;
  logic        op_st;
  logic [8:0]  op_regno;
  logic        except;
  logic        except_gate;
  logic        except_in_km;
  logic        bus_hold;
  logic        csr_en;
  logic [15:0] csr_no;
  logic [63:0] csr_data;
  logic        fill_en = 1'b0;
  logic [20:0] fill_ctx = '0;
  logic [30:0] fill_vpage = '0;
  logic [30:0] fill_ppage = '0;
  logic        fill_sys = 1'b0;
  logic        fill_present = 1'b0;
  logic        stall;
  logic        mop_en;
  logic        tlb_miss;
  logic [31:0] banks;
  logic [43:8] addr_even;
  logic [43:8] addr_odd;
  logic        odd;
  logic [8:0]  regno;
  logic        page_fault;
  logic [7:0]  fault_code;
  logic [8:0]  fault_no;

  int          tb_errors = 0;
  logic [31:0] rng = 32'd17;
  logic [31:0] r;
  logic [20:0] cur_ctx;
  logic [30:0] cur_vp;
  logic        cur_cross;
  logic        fill_second;
  logic [30:0] fill_vp;
  logic        missed;

  agu_top i_dut (.*);

  agu_checker i_chk (.*);

  initial begin
    clk = 1'b0;
    forever #4 clk = ~clk;
  end

  function automatic logic [31:0] xorshift(logic [31:0] s);
    s = s ^ (s << 13);
    s = s ^ (s >> 17);
    s = s ^ (s << 5);
    return s;
  endfunction

  task automatic next_rand(output logic [31:0] v);
    rng = xorshift(rng);
    v   = rng;
  endtask

  // vpage bits 7:4 of A mark a system page and B an absent one
  function automatic logic [30:0] page_ppage(logic [20:0] c, logic [30:0] vp);
    return vp * 31'd7 + 31'(c) + 31'h40000;
  endfunction

  // one page per miss and for a crossing split the next page after it
  always @(posedge clk) begin
    if (rst) begin
      fill_en     <= 1'b0;
      fill_second <= 1'b0;
    end else if (fill_en) begin
      fill_en <= 1'b0;
    end else if (tlb_miss) begin
      fill_vp = fill_second ? cur_vp + 31'd1 : cur_vp;
      fill_en      <= 1'b1;
      fill_ctx     <= cur_ctx;
      fill_vpage   <= fill_vp;
      fill_ppage   <= page_ppage(cur_ctx, fill_vp);
      fill_sys     <= fill_vp[7:4] == 4'hA;
      fill_present <= fill_vp[7:4] != 4'hB;
      fill_second  <= cur_cross && !fill_second;
    end else if (mop_en) begin
      fill_second <= 1'b0;
    end
  end

  task automatic csr_write(logic [15:0] no, logic [63:0] data);
    @(posedge clk);
    csr_en   <= 1'b1;
    csr_no   <= no;
    csr_data <= data;
    @(posedge clk);
    csr_en <= 1'b0;
  endtask

  task automatic raise_exception(logic km);
    @(posedge clk);
    except       <= 1'b1;
    except_gate  <= 1'b1;
    except_in_km <= km;
    @(posedge clk);
    except      <= 1'b0;
    except_gate <= 1'b0;
  endtask

  task automatic issue_op(logic [43:0] addr, logic [4:0] size, logic [4:0] bank0,
                          logic split, logic [8:0] rn, int hold, output logic miss_seen);
    int t;
    miss_seen = 1'b0;
    t         = 0;
    cur_vp    = addr[43:13];
    cur_cross = split && (&addr[12:7]);
    @(posedge clk);
    op_en    <= 1'b1;
    op_addr  <= addr;
    op_size  <= size;
    op_bank0 <= bank0;
    op_split <= split;
    op_st    <= rn[0];
    op_regno <= rn;
    @(posedge clk);
    op_en <= 1'b0;
    if (hold > 0) begin
      bus_hold <= 1'b1;
      repeat (hold) begin
        @(negedge clk);
        if (tlb_miss) miss_seen = 1'b1;
        if (mop_en) begin
          tb_errors++;
          $display("ERR %0t mop_en got 1 expected 0 while bus_hold is high", $time);
        end
      end
      @(posedge clk);
      bus_hold <= 1'b0;
    end
    @(negedge clk);
    while (!mop_en && t < 200) begin
      if (tlb_miss) miss_seen = 1'b1;
      @(negedge clk);
      t++;
    end
    if (!mop_en) begin
      tb_errors++;
      $display("operation at address %h never completed", addr);
    end
  endtask

  task automatic expect_miss(logic got, logic exp, string what);
    if (got !== exp) begin
      tb_errors++;
      $display("ERR %0t tlb_miss (%s) got %0d expected %0d", $time, what, got, exp);
    end
  endtask

  initial begin
    rst = 1'b1;
    {op_en, op_addr, op_size, op_bank0, op_split, op_st, op_regno} = '0;
    {except, except_gate, except_in_km, bus_hold} = '0;
    {csr_en, csr_no, csr_data} = '0;
    cur_ctx   = 21'd5;
    cur_vp    = '0;
    cur_cross = 1'b0;
    repeat (3) @(posedge clk);
    rst <= 1'b0;

    csr_write(`AGU_CSR_PAGE, {21'd5, 43'd0});
    csr_write(`AGU_CSR_MFLAGS, 64'd3);

    // random user-page accesses
    for (int i = 0; i < 40; i++) begin
      next_rand(r);
      issue_op({31'h100 + 31'(r[31:29] % 6), r[12:0]}, r[17:13], r[22:18], r[23], r[8:0],
               0, missed);
    end

    // every size code with every low address pair
    for (int s = 0; s < 32; s++) begin
      for (int l = 0; l < 4; l++) begin
        next_rand(r);
        issue_op({31'h100, r[12:2], 2'(l)}, 5'(s), r[27:23], 1'b0, r[8:0], 0, missed);
      end
    end

    // fresh pages miss and the round robin evicts the oldest
    for (int i = 0; i < 12; i++) begin
      issue_op({31'h200 + 31'(i), 13'h0a4}, 5'd16, 5'd3, 1'b0, 9'(i), 0, missed);
      expect_miss(missed, 1'b1, "fresh page");
    end
    issue_op({31'h20b, 13'h1000}, 5'd17, 5'd9, 1'b0, 9'h1ab, 0, missed);
    expect_miss(missed, 1'b0, "recent page");

    // refill of a present page keeps the round-robin slot
    issue_op({31'h20b, 13'h1f80}, 5'd16, 5'd5, 1'b1, 9'h1ad, 0, missed);
    expect_miss(missed, 1'b1, "page after a present page");
    issue_op({31'h205, 13'h0100}, 5'd16, 5'd5, 1'b0, 9'h1ae, 0, missed);
    expect_miss(missed, 1'b0, "page kept over a tag overwrite");

    issue_op({31'h200, 13'h1000}, 5'd17, 5'd9, 1'b0, 9'h1ac, 0, missed);
    expect_miss(missed, 1'b1, "evicted page");

    // split operations across a page boundary
    issue_op({31'h300, 13'h1f81}, 5'd15, 5'd30, 1'b1, 9'h033, 0, missed);
    issue_op({31'h310, 13'h1fff}, 5'd0, 5'd31, 1'b1, 9'h034, 0, missed);

    // system and absent pages at user level, then at level 0
    issue_op({31'h3a0, 13'h0100}, 5'd16, 5'd0, 1'b0, 9'h040, 0, missed);
    issue_op({31'h3b0, 13'h0100}, 5'd16, 5'd0, 1'b0, 9'h041, 0, missed);
    issue_op({31'h3af, 13'h1f80}, 5'd19, 5'd2, 1'b1, 9'h042, 0, missed);
    csr_write(`AGU_CSR_MFLAGS, 64'd0);
    issue_op({31'h3a0, 13'h0180}, 5'd16, 5'd0, 1'b0, 9'h043, 0, missed);

    // old translations miss in a new context
    cur_ctx = 21'd9;
    csr_write(`AGU_CSR_PAGE, {21'd9, 43'd0});
    issue_op({31'h100, 13'h0040}, 5'd18, 5'd4, 1'b0, 9'h050, 0, missed);
    expect_miss(missed, 1'b1, "page after context switch");

    // exception drops to user level, then back to kernel level
    raise_exception(1'b0);
    issue_op({31'h3a0, 13'h0200}, 5'd16, 5'd1, 1'b0, 9'h060, 0, missed);
    raise_exception(1'b1);
    issue_op({31'h3a0, 13'h0280}, 5'd16, 5'd1, 1'b0, 9'h061, 0, missed);

    // back-pressure holds the operation
    issue_op({31'h100, 13'h0300}, 5'd8, 5'd12, 1'b0, 9'h070, 6, missed);
    issue_op({31'h105, 13'h0301}, 5'd3, 5'd14, 1'b0, 9'h071, 4, missed);

    repeat (4) @(posedge clk);
    $display("errors: checker %0d, testbench %0d", i_chk.errors, tb_errors);
    if (i_chk.errors == 0 && tb_errors == 0) begin
      $display("test passed");
    end else begin
      $display("test failed");
    end
    $finish;
  end

endmodule

// File: tb.f
+incdir+source
source/agu_pkg.sv
source/tlb_lookup_if.sv
source/bank_mask.sv
source/agu_ctx.sv
source/dtlb_small.sv
source/agu_stage.sv
source/agu_top.sv
dv/agu_asserts.sv
dv/agu_checker.sv
dv/agu_tb.sv

// File: Makefile
VERILATOR ?= verilator
TOP       ?= agu_tb
BUILD     ?= obj_dir
FILELIST  ?= tb.f
VFLAGS    ?= --binary --timing --assert -Wno-fatal

.PHONY: sim clean

sim:
	$(VERILATOR) $(VFLAGS) -f $(FILELIST) --top-module $(TOP) --Mdir $(BUILD) -o sim_$(TOP)
	@out="$$(./$(BUILD)/sim_$(TOP))"; \
	echo "$$out"; \
	echo "$$out" | grep -qx "test passed"

clean:
	rm -rf $(BUILD)
